// ==== hw/dbus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// dbus_pkg
// shared bus constants, address views and the request, response and lane records
// ~~~~~~~~~~~~~~~~~~~~

package dbus_pkg;

    localparam int NCORES        = 4;
    localparam int PORT_W        = 2;
    localparam int CREDITS       = 2;      // request slots per port
    localparam int DMEM_WORDS    = 1024;
    localparam int DMEM_AW       = 10;
    localparam int MMIO_HART_BIT = 12;     // set selects hart reg, clear the counter

    localparam logic [2:0] REGION_DMEM = 3'b001;
    localparam logic [2:0] REGION_MMIO = 3'b100;

    typedef logic [1:0] cnt_ctrl_t;

    localparam cnt_ctrl_t CNT_CLEAR = 2'd0;
    localparam cnt_ctrl_t CNT_RUN   = 2'd1;
    localparam cnt_ctrl_t CNT_HOLD  = 2'd2;

    typedef struct packed {
        logic                  hi_unused;
        logic [2:0]            region;     // bits 30:28
        logic [25-DMEM_AW:0]   unused;
        logic [DMEM_AW-1:0]    word;
        logic [1:0]            offset;
    } dmem_addr_t;

    typedef struct packed {
        logic                       hi_unused;
        logic [2:0]                 region;
        logic [26-MMIO_HART_BIT:0]  unused;
        logic                       hart_sel;
        logic [MMIO_HART_BIT-1:0]   offset;  // register offset
    } mmio_addr_t;

    // one address word, read as memory or as register space
    typedef union packed {
        dmem_addr_t dmem;
        mmio_addr_t mmio;
    } dbus_addr_u;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic        lr;
        logic        sc;
        dbus_addr_u  addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } dbus_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
        logic        sc_fail;
    } dbus_resp_t;

    typedef struct packed {
        logic               valid;
        logic               write;     // also set for sc
        logic               lr;
        logic               sc;
        logic [DMEM_AW-1:0] word;
        logic [31:0]        wdata;
        logic [3:0]         wstrb;
    } dmem_req_t;

    typedef struct packed {
        logic               valid;
        logic [PORT_W-1:0]  port;
        logic               write;
        logic               lr;
        logic               sc;
        logic [DMEM_AW-1:0] word;
        logic [31:0]        wdata;
        logic [3:0]         wstrb;
    } lane_t;

endpackage

// ==== hw/dmem_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// dmem_bank
// two-lane data memory, byte-strobe writes, registered reads
// ~~~~~~~~~~~~~~~~~~~~

module dmem_bank (
    input  logic             clk_i,
    input  dbus_pkg::lane_t  lane_i [2],
    input  logic [1:0]       we_i,
    output logic [31:0]      rdata_o [2]
);
    import dbus_pkg::*;

    logic [31:0] mem_q [DMEM_WORDS];

    // lanes never share a word in one cycle
    always_ff @(posedge clk_i) begin
        for (int l = 0; l < 2; l++) begin
            for (int b = 0; b < 4; b++) begin
                if (we_i[l] && lane_i[l].wstrb[b]) begin
                    mem_q[lane_i[l].word][8*b +: 8] <= lane_i[l].wdata[8*b +: 8];
                end
            end
            if (lane_i[l].valid) begin
                rdata_o[l] <= mem_q[lane_i[l].word];   // old data on a write
            end
        end
    end

endmodule

// ==== hw/reservation_table.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// reservation_table
// lr/sc reservations per port, sc verdicts and write snooping
// ~~~~~~~~~~~~~~~~~~~~

module reservation_table (
    input  logic             clk_i,
    input  logic             rst,
    input  dbus_pkg::lane_t  lane_i [2],
    output logic [1:0]       sc_ok_o
);
    import dbus_pkg::*;

    logic [NCORES-1:0]  res_vld_q;
    logic [DMEM_AW-1:0] res_word_q [NCORES];
    logic [1:0]         wr_done;             // write really performed
    logic [NCORES-1:0]  res_set;
    logic [NCORES-1:0]  res_clr;
    logic [DMEM_AW-1:0] set_word [NCORES];

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            sc_ok_o[l] = lane_i[l].valid && lane_i[l].sc && res_vld_q[lane_i[l].port] &&
                         (res_word_q[lane_i[l].port] == lane_i[l].word);
            wr_done[l] = lane_i[l].valid && lane_i[l].write && (!lane_i[l].sc || sc_ok_o[l]);
        end
    end

    // own lr wins over any snoop in the same cycle
    always_comb begin
        for (int p = 0; p < NCORES; p++) begin
            res_set[p]  = 1'b0;
            res_clr[p]  = 1'b0;
            set_word[p] = res_word_q[p];
            for (int l = 0; l < 2; l++) begin
                if (lane_i[l].valid && lane_i[l].port == PORT_W'(p)) begin
                    if (lane_i[l].lr) begin
                        res_set[p]  = 1'b1;
                        set_word[p] = lane_i[l].word;
                    end
                    if (lane_i[l].sc) res_clr[p] = 1'b1;
                end else if (wr_done[l] && lane_i[l].word == res_word_q[p]) begin
                    res_clr[p] = 1'b1;                    // other port hit our word
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            res_vld_q <= '0;
        end else begin
            for (int p = 0; p < NCORES; p++) begin
                if (res_set[p]) res_vld_q[p] <= 1'b1;
                else if (res_clr[p]) res_vld_q[p] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NCORES; p++) begin
            res_word_q[p] <= set_word[p];
        end
    end

endmodule

// ==== hw/cycle_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// cycle_counter
// shared 64-bit cycle count with clear, run and hold
// ~~~~~~~~~~~~~~~~~~~~

module cycle_counter (
    input  logic                         clk_i,
    input  logic                         rst,
    input  logic [dbus_pkg::NCORES-1:0]  cnt_we_i,
    input  dbus_pkg::cnt_ctrl_t          cnt_ctrl_i [dbus_pkg::NCORES],
    output logic [63:0]                  count_o
);
    import dbus_pkg::*;

    cnt_ctrl_t ctrl_q;
    cnt_ctrl_t ctrl_d;

    // lowest writing port wins
    always_comb begin
        ctrl_d = ctrl_q;
        for (int p = NCORES - 1; p >= 0; p--) begin
            if (cnt_we_i[p]) ctrl_d = cnt_ctrl_i[p];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            ctrl_q  <= CNT_CLEAR;
            count_o <= '0;
        end else begin
            ctrl_q <= ctrl_d;
            case (ctrl_q)
                CNT_CLEAR: count_o <= '0;
                CNT_RUN:   count_o <= count_o + 64'd1;
                CNT_HOLD:  ;
                default:   ;                 // unused code holds too
            endcase
        end
    end

endmodule

// ==== hw/dmem_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// dmem_arbiter
// round-robin pick of up to two heads on distinct words, and return routing
// ~~~~~~~~~~~~~~~~~~~~

module dmem_arbiter (
    input  logic                         clk_i,
    input  logic                         rst,
    input  dbus_pkg::dmem_req_t          head_i [dbus_pkg::NCORES],
    output logic [dbus_pkg::NCORES-1:0]  grant_o,
    output dbus_pkg::lane_t              lane_o [2],
    output logic [1:0]                   bank_we_o,
    input  logic [1:0]                   sc_ok_i,
    output logic [dbus_pkg::NCORES-1:0]  rvalid_o,
    output logic [31:0]                  rdata_o [dbus_pkg::NCORES],
    output logic [dbus_pkg::NCORES-1:0]  sc_fail_o,
    input  logic [31:0]                  bank_rdata_i [2]
);
    import dbus_pkg::*;

    logic [PORT_W-1:0] rr_ptr;
    logic [PORT_W-1:0] sel_a;
    logic [PORT_W-1:0] sel_b;
    logic              sel_a_vld;
    logic              sel_b_vld;
    lane_t             lane_q [2];    // tags of last cycle's lanes
    logic [1:0]        sc_fail_q;

    function automatic lane_t make_lane(input logic vld, input logic [PORT_W-1:0] port,
                                        input dmem_req_t h);
        lane_t l;
        l.valid = vld;
        l.port  = port;
        l.write = h.write;
        l.lr    = h.lr;
        l.sc    = h.sc;
        l.word  = h.word;
        l.wdata = h.wdata;
        l.wstrb = h.wstrb;
        return l;
    endfunction

    always_comb begin
        logic [PORT_W-1:0] idx;
        sel_a_vld = 1'b0;
        sel_b_vld = 1'b0;
        sel_a     = '0;
        sel_b     = '0;
        idx       = '0;
        for (int k = 0; k < NCORES; k++) begin
            idx = rr_ptr + PORT_W'(k);
            if (!sel_a_vld && head_i[idx].valid) begin
                sel_a_vld = 1'b1;
                sel_a     = idx;
            end
        end
        // second lane must not hit lane a's word
        for (int k = 0; k < NCORES; k++) begin
            idx = rr_ptr + PORT_W'(k);
            if (sel_a_vld && !sel_b_vld && head_i[idx].valid && idx != sel_a &&
                head_i[idx].word != head_i[sel_a].word) begin
                sel_b_vld = 1'b1;
                sel_b     = idx;
            end
        end
    end

    assign lane_o[0] = make_lane(sel_a_vld, sel_a, head_i[sel_a]);
    assign lane_o[1] = make_lane(sel_b_vld, sel_b, head_i[sel_b]);

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            bank_we_o[l] = lane_o[l].valid && lane_o[l].write && (!lane_o[l].sc || sc_ok_i[l]);
        end
        for (int p = 0; p < NCORES; p++) begin
            grant_o[p] = (sel_a_vld && sel_a == PORT_W'(p)) ||
                         (sel_b_vld && sel_b == PORT_W'(p));
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (sel_b_vld) begin
            rr_ptr <= sel_b + 1'b1;
        end else if (sel_a_vld) begin
            rr_ptr <= sel_a + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int l = 0; l < 2; l++) begin
            if (rst) begin
                lane_q[l].valid <= 1'b0;
                sc_fail_q[l]    <= 1'b0;
            end else begin
                lane_q[l]    <= lane_o[l];
                sc_fail_q[l] <= lane_o[l].sc && !sc_ok_i[l];
            end
        end
    end

    // steer bank words back to their owners
    always_comb begin
        for (int p = 0; p < NCORES; p++) begin
            rvalid_o[p]  = 1'b0;
            rdata_o[p]   = '0;
            sc_fail_o[p] = 1'b0;
            for (int l = 0; l < 2; l++) begin
                if (lane_q[l].valid && lane_q[l].port == PORT_W'(p)) begin
                    rvalid_o[p]  = 1'b1;
                    rdata_o[p]   = lane_q[l].write ? '0 : bank_rdata_i[l];
                    sc_fail_o[p] = sc_fail_q[l];
                end
            end
        end
    end

endmodule

// ==== hw/dbus_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// dbus_port
// per-core request queue, region decode, local mmio replies and in-order responses
// ~~~~~~~~~~~~~~~~~~~~

module dbus_port (
    input  logic                         clk_i,
    input  logic                         rst,
    input  logic [dbus_pkg::PORT_W-1:0]  hart_idx_i,   // fixed per instance
    input  dbus_pkg::dbus_req_t          req_i,
    output logic                         credit_o,
    output dbus_pkg::dbus_resp_t         resp_o,
    output dbus_pkg::dmem_req_t          head_o,
    input  logic                         grant_i,
    input  logic                         dmem_rvalid_i,
    input  logic [31:0]                  dmem_rdata_i,
    input  logic                         sc_fail_i,
    input  logic [63:0]                  count_i,
    output logic                         cnt_we_o,
    output dbus_pkg::cnt_ctrl_t          cnt_ctrl_o
);
    import dbus_pkg::*;

    dbus_req_t                          q_mem [CREDITS];
    logic [$clog2(CREDITS)-1:0]         wr_ptr_q;
    logic [$clog2(CREDITS)-1:0]         rd_ptr_q;
    logic [$clog2(CREDITS+1)-1:0]       count_q;
    dbus_req_t                          head;
    logic                               head_vld;
    logic                               is_dmem;
    logic                               is_mmio;
    logic                               local_take;   // mmio or unmapped head
    logic                               push;
    logic                               pop;
    logic [31:0]                        mmio_rdata;
    logic                               local_vld_q;
    logic [31:0]                        local_rdata_q;
    logic                               credit_q;

    assign push     = req_i.valid;
    assign head     = q_mem[rd_ptr_q];
    assign head_vld = (count_q != '0);
    assign is_dmem  = (head.addr.dmem.region == REGION_DMEM);
    assign is_mmio  = (head.addr.mmio.region == REGION_MMIO);

    assign local_take = head_vld && !is_dmem;
    assign pop        = grant_i || local_take;

    always_ff @(posedge clk_i) begin
        if (push) begin
            q_mem[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_comb begin
        head_o.valid = head_vld && is_dmem;
        head_o.write = head.write || head.sc;
        head_o.lr    = head.lr;
        head_o.sc    = head.sc;
        head_o.word  = head.addr.dmem.word;
        head_o.wdata = head.wdata;
        head_o.wstrb = head.wstrb;
    end

    // register reads, writes read back zero
    always_comb begin
        mmio_rdata = '0;
        if (is_mmio && !head.write) begin
            if (head.addr.mmio.hart_sel) begin
                mmio_rdata = 32'(hart_idx_i);
            end else if (head.addr.mmio.offset[2]) begin
                mmio_rdata = count_i[31:0];    // low word
            end else begin
                mmio_rdata = count_i[63:32];
            end
        end
    end

    assign cnt_we_o   = local_take && is_mmio && head.write && !head.addr.mmio.hart_sel &&
                        (head.addr.mmio.offset == '0);
    assign cnt_ctrl_o = head.wdata[1:0];

    always_ff @(posedge clk_i) begin
        if (rst) begin
            local_vld_q <= 1'b0;
            credit_q    <= 1'b0;
        end else begin
            local_vld_q <= local_take;
            credit_q    <= pop;           // one credit back per dequeue
        end
    end

    always_ff @(posedge clk_i) begin
        local_rdata_q <= mmio_rdata;
    end

    assign credit_o = credit_q;

    // only one dequeue per cycle, so the two sources never collide
    always_comb begin
        resp_o.valid   = dmem_rvalid_i || local_vld_q;
        resp_o.rdata   = dmem_rvalid_i ? dmem_rdata_i : local_rdata_q;
        resp_o.sc_fail = dmem_rvalid_i && sc_fail_i;
    end

endmodule

// ==== hw/dbus_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// dbus_top
// four core ports sharing one dual-port data memory, plus reservations and counter
// ~~~~~~~~~~~~~~~~~~~~

module dbus_top (
    input  logic                         clk_i,
    input  logic                         rst,
    input  dbus_pkg::dbus_req_t          req_i [dbus_pkg::NCORES],
    output logic [dbus_pkg::NCORES-1:0]  credit_o,
    output dbus_pkg::dbus_resp_t         resp_o [dbus_pkg::NCORES]
);
    import dbus_pkg::*;

    dmem_req_t         head [NCORES];
    logic [NCORES-1:0] grant;
    logic [NCORES-1:0] dmem_rvalid;
    logic [31:0]       dmem_rdata [NCORES];
    logic [NCORES-1:0] sc_fail;
    lane_t             lane [2];
    logic [1:0]        bank_we;
    logic [1:0]        sc_ok;
    logic [31:0]       bank_rdata [2];
    logic [NCORES-1:0] cnt_we;
    cnt_ctrl_t         cnt_ctrl [NCORES];
    logic [63:0]       count;

    for (genvar i = 0; i < NCORES; i++) begin : g_port
        dbus_port u_port (
            .clk_i         (clk_i),
            .rst           (rst),
            .hart_idx_i    (PORT_W'(i)),
            .req_i         (req_i[i]),
            .credit_o      (credit_o[i]),
            .resp_o        (resp_o[i]),
            .head_o        (head[i]),
            .grant_i       (grant[i]),
            .dmem_rvalid_i (dmem_rvalid[i]),
            .dmem_rdata_i  (dmem_rdata[i]),
            .sc_fail_i     (sc_fail[i]),
            .count_i       (count),
            .cnt_we_o      (cnt_we[i]),
            .cnt_ctrl_o    (cnt_ctrl[i])
        );
    end

    dmem_arbiter u_arbiter (
        .clk_i        (clk_i),
        .rst          (rst),
        .head_i       (head),
        .grant_o      (grant),
        .lane_o       (lane),
        .bank_we_o    (bank_we),
        .sc_ok_i      (sc_ok),
        .rvalid_o     (dmem_rvalid),
        .rdata_o      (dmem_rdata),
        .sc_fail_o    (sc_fail),
        .bank_rdata_i (bank_rdata)
    );

    dmem_bank u_bank (
        .clk_i   (clk_i),
        .lane_i  (lane),
        .we_i    (bank_we),
        .rdata_o (bank_rdata)
    );

    reservation_table u_resv (
        .clk_i   (clk_i),
        .rst     (rst),
        .lane_i  (lane),
        .sc_ok_o (sc_ok)
    );

    cycle_counter u_counter (
        .clk_i      (clk_i),
        .rst        (rst),
        .cnt_we_i   (cnt_we),
        .cnt_ctrl_i (cnt_ctrl),
        .count_o    (count)
    );

endmodule

// ==== dv/tb_clock.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// tb_clock
// free-running testbench clock, period 8
// ~~~~~~~~~~~~~~~~~~~~

module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #4 clk_o = ~clk_o;    // half period

endmodule

// ==== dv/dbus_tb_checks.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// dbus_tb_checks
// response compare tasks and error counters for the bus testbench
// ~~~~~~~~~~~~~~~~~~~~

`ifndef DBUS_TB_CHECKS_SVH
`define DBUS_TB_CHECKS_SVH

int rdata_errs = 0;
int sc_errs    = 0;
int cnt_errs   = 0;
int other_errs = 0;

task automatic check_rdata(input string name, input logic [31:0] exp, input dbus_resp_t act);
    if (act.rdata !== exp) begin
        rdata_errs++;
        $display("error %s: rdata expected %h, actual %h", name, exp, act.rdata);
    end
endtask

task automatic check_sc_fail(input string name, input logic exp, input dbus_resp_t act);
    if (act.sc_fail !== exp) begin
        sc_errs++;
        $display("error %s: sc_fail expected %b, actual %b", name, exp, act.sc_fail);
    end
endtask

// counter must have moved past the earlier sample
task automatic check_counter_rise(input string name, input logic [31:0] prev,
                                  input dbus_resp_t act);
    if (!(act.rdata > prev)) begin
        cnt_errs++;
        $display("error %s: count expected above %h, actual %h", name, prev, act.rdata);
    end
endtask

task automatic report_problem(input string msg);
    other_errs++;
    $display("%s", msg);
endtask

`endif

// ==== dv/dbus_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// dbus_tb
// table-driven testbench for the shared data bus
// ~~~~~~~~~~~~~~~~~~~~

module dbus_tb;
    import dbus_pkg::*;

    `include "dbus_tb_checks.svh"

    localparam int TIMEOUT_CYCLES = 200;

    typedef enum int {K_MATCH, K_CNT_FIRST, K_CNT_NEXT} step_kind_e;

    typedef struct {
        string       name;
        int          port;
        dbus_req_t   req;
        logic [31:0] exp_rdata;
        logic        exp_sc_fail;
        step_kind_e  kind;
        bit          wait_done;   // drain all responses after this step
        bit          same_cycle;  // issued together with the step before it
    } step_t;

    logic              clk_i;
    logic              rst;
    dbus_req_t         req [NCORES];
    logic [NCORES-1:0] credit;
    dbus_resp_t        resp [NCORES];

    step_t       steps [$];
    int          exp_q [NCORES][$];   // step indices awaiting a response
    int          sent [NCORES] = '{default: 0};
    int          returned [NCORES] = '{default: 0};
    logic [31:0] cnt_prev = '0;
    bit          timed_out = 1'b0;

    tb_clock u_clock (.clk_o(clk_i));

    dbus_top dut_i (
        .clk_i    (clk_i),
        .rst      (rst),
        .req_i    (req),
        .credit_o (credit),
        .resp_o   (resp)
    );

    function automatic dbus_req_t mem_req(input logic wr, input logic lr, input logic sc,
                                          input int word, input logic [31:0] data,
                                          input logic [3:0] strb);
        dbus_req_t r;
        r.valid = 1'b1;
        r.write = wr;
        r.lr    = lr;
        r.sc    = sc;
        r.addr  = {1'b0, REGION_DMEM, 16'h0, DMEM_AW'(word), 2'b00};
        r.wdata = data;
        r.wstrb = strb;
        return r;
    endfunction

    function automatic dbus_req_t mmio_req(input logic wr, input logic hart,
                                           input logic [11:0] offset, input logic [31:0] data);
        dbus_req_t r;
        r.valid = 1'b1;
        r.write = wr;
        r.lr    = 1'b0;
        r.sc    = 1'b0;
        r.addr  = {1'b0, REGION_MMIO, 15'h0, hart, offset};
        r.wdata = data;
        r.wstrb = 4'hf;
        return r;
    endfunction

    function automatic void add_step(input string name, input int port, input dbus_req_t r,
                                     input logic [31:0] rdata, input logic sc_fail,
                                     input step_kind_e kind, input bit wait_done,
                                     input bit same_cycle = 1'b0);
        step_t s;
        s.name        = name;
        s.port        = port;
        s.req         = r;
        s.exp_rdata   = rdata;
        s.exp_sc_fail = sc_fail;
        s.kind        = kind;
        s.wait_done   = wait_done;
        s.same_cycle  = same_cycle;
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        int rp;
        rp = int'($urandom % NCORES);
        add_step("merge_full_write", rp, mem_req(1, 0, 0, 16, 32'h1122_3344, 4'hf),
                 '0, 1'b0, K_MATCH, 1);
        rp = int'($urandom % NCORES);
        add_step("merge_strobe_write", rp, mem_req(1, 0, 0, 16, 32'haabb_ccdd, 4'b0101),
                 '0, 1'b0, K_MATCH, 1);
        rp = int'($urandom % NCORES);
        add_step("merge_read", rp, mem_req(0, 0, 0, 16, '0, 4'h0),
                 32'h11bb_33dd, 1'b0, K_MATCH, 1);
        // all ports issue together on both credits
        for (int k = 0; k < 2; k++) begin
            for (int p = 0; p < NCORES; p++) begin
                add_step($sformatf("burst_write_p%0d_%0d", p, k), p,
                         mem_req(1, 0, 0, 32 + 2 * p + k, {16'hc0de, 8'(p), 8'(k)}, 4'hf),
                         '0, 1'b0, K_MATCH, (p == NCORES - 1) && (k == 1), p != 0);
            end
        end
        for (int k = 0; k < 2; k++) begin
            for (int p = 0; p < NCORES; p++) begin
                add_step($sformatf("burst_read_p%0d_%0d", p, k), p,
                         mem_req(0, 0, 0, 32 + 2 * p + k, '0, 4'h0),
                         {16'hc0de, 8'(p), 8'(k)}, 1'b0, K_MATCH,
                         (p == NCORES - 1) && (k == 1), p != 0);
            end
        end
        for (int p = 0; p < NCORES; p++) begin
            add_step($sformatf("hart_read_p%0d", p), p, mmio_req(0, 1, 12'h0, '0),
                     32'(p), 1'b0, K_MATCH, 1);
        end
        // lr/sc with nobody in between
        add_step("lrsc_init", 0, mem_req(1, 0, 0, 64, 32'h1111_2222, 4'hf), '0, 1'b0, K_MATCH, 1);
        add_step("lrsc_lr", 0, mem_req(0, 1, 0, 64, '0, 4'h0), 32'h1111_2222, 1'b0, K_MATCH, 1);
        add_step("lrsc_sc", 0, mem_req(1, 0, 1, 64, 32'haaaa_5555, 4'hf), '0, 1'b0, K_MATCH, 1);
        add_step("lrsc_read", 0, mem_req(0, 0, 0, 64, '0, 4'h0), 32'haaaa_5555, 1'b0, K_MATCH, 1);
        // port 1 breaks port 0's reservation
        add_step("snoop_init", 2, mem_req(1, 0, 0, 65, 32'h0bad_f00d, 4'hf), '0, 1'b0, K_MATCH, 1);
        add_step("snoop_lr", 0, mem_req(0, 1, 0, 65, '0, 4'h0), 32'h0bad_f00d, 1'b0, K_MATCH, 1);
        add_step("snoop_write", 1, mem_req(1, 0, 0, 65, 32'h1234_5678, 4'hf), '0, 1'b0, K_MATCH, 1);
        add_step("snoop_sc", 0, mem_req(1, 0, 1, 65, 32'hdead_beef, 4'hf), '0, 1'b1, K_MATCH, 1);
        add_step("snoop_read", 0, mem_req(0, 0, 0, 65, '0, 4'h0), 32'h1234_5678, 1'b0, K_MATCH, 1);
        rp = int'($urandom % NCORES);
        // counter runs first so that the clear has something to undo
        add_step("cnt_prerun", rp, mmio_req(1, 0, 12'h0, 32'(CNT_RUN)), '0, 1'b0, K_MATCH, 1);
        add_step("cnt_clear", rp, mmio_req(1, 0, 12'h0, 32'(CNT_CLEAR)), '0, 1'b0, K_MATCH, 1);
        add_step("cnt_hold", rp, mmio_req(1, 0, 12'h0, 32'(CNT_HOLD)), '0, 1'b0, K_MATCH, 1);
        rp = int'($urandom % NCORES);
        add_step("cnt_read_high", rp, mmio_req(0, 0, 12'h0, '0), '0, 1'b0, K_MATCH, 1);
        add_step("cnt_read_low", rp, mmio_req(0, 0, 12'h4, '0), '0, 1'b0, K_MATCH, 1);
        add_step("cnt_run", rp, mmio_req(1, 0, 12'h0, 32'(CNT_RUN)), '0, 1'b0, K_MATCH, 1);
        rp = int'($urandom % NCORES);
        add_step("cnt_run_first", rp, mmio_req(0, 0, 12'h4, '0), '0, 1'b0, K_CNT_FIRST, 1);
        add_step("cnt_run_second", rp, mmio_req(0, 0, 12'h4, '0), '0, 1'b0, K_CNT_NEXT, 1);
    endfunction

    task automatic check_response(input step_t s, input dbus_resp_t act);
        case (s.kind)
            K_MATCH:     check_rdata(s.name, s.exp_rdata, act);
            K_CNT_FIRST: cnt_prev = act.rdata;
            K_CNT_NEXT:  check_counter_rise(s.name, cnt_prev, act);
            default:     ;
        endcase
        check_sc_fail(s.name, s.exp_sc_fail, act);
    endtask

    task automatic clear_reqs();
        for (int p = 0; p < NCORES; p++) begin
            req[p] <= '0;
        end
    endtask

    // waits for a credit, then drives the request for one cycle
    task automatic issue(input int idx);
        int p;
        int waited;
        p      = steps[idx].port;
        waited = 0;
        if (!steps[idx].same_cycle) begin
            @(posedge clk_i);
            clear_reqs();
        end
        while (sent[p] - returned[p] >= CREDITS) begin
            clear_reqs();
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_problem($sformatf("no credit came back on port %0d before %s",
                                         p, steps[idx].name));
                timed_out = 1'b1;
                return;
            end
            @(posedge clk_i);
        end
        req[p] <= steps[idx].req;
        sent[p]++;
        exp_q[p].push_back(idx);
    endtask

    function automatic bit pending();
        bit any;
        any = 1'b0;
        for (int p = 0; p < NCORES; p++) begin
            if (exp_q[p].size() != 0) any = 1'b1;
        end
        return any;
    endfunction

    task automatic drain(input string name);
        int waited;
        waited = 0;
        @(posedge clk_i);
        clear_reqs();
        while (pending()) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_problem($sformatf("responses for %s never arrived", name));
                timed_out = 1'b1;
                return;
            end
            @(posedge clk_i);
        end
    endtask

    // responses and credits are read on the falling edge
    always @(negedge clk_i) begin
        int idx;
        if (!rst) begin
            for (int p = 0; p < NCORES; p++) begin
                if (credit[p]) returned[p]++;
                if (resp[p].valid) begin
                    if (exp_q[p].size() == 0) begin
                        report_problem($sformatf("port %0d gave a response nobody asked for", p));
                    end else begin
                        idx = exp_q[p].pop_front();
                        check_response(steps[idx], resp[p]);
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h3e72_9149));
        rst = 1'b1;
        for (int p = 0; p < NCORES; p++) begin
            req[p] = '0;
        end
        build_table();
        repeat (2) @(posedge clk_i);
        rst <= 1'b0;
        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            issue(i);
            if (!timed_out && steps[i].wait_done) drain(steps[i].name);
        end
        if (!timed_out) begin
            for (int p = 0; p < NCORES; p++) begin
                if (sent[p] != returned[p]) begin
                    report_problem($sformatf("port %0d returned %0d credits for %0d requests",
                                             p, returned[p], sent[p]));
                end
            end
        end
        $display("errors: rdata %0d, sc_fail %0d, counter %0d, other %0d",
                 rdata_errs, sc_errs, cnt_errs, other_errs);
        if (!timed_out && rdata_errs == 0 && sc_errs == 0 && cnt_errs == 0 &&
            other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+dv
hw/dbus_pkg.sv
hw/dmem_bank.sv
hw/reservation_table.sv
hw/cycle_counter.sv
hw/dmem_arbiter.sv
hw/dbus_port.sv
hw/dbus_top.sv
dv/tb_clock.sv
dv/dbus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the data bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module dbus_tb \
    --Mdir obj_dir -o dbus_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/dbus_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
